/* rtl/expand_pkg.sv */
// Shared sizes, types, register map and coefficient rules for the 1x1 expand engine
package expand_pkg;

	////////////////////////////////////////////////////////////
	// Engine sizes
	////////////////////////////////////////////////////////////
	localparam int CHIN     = 4;
	localparam int CHOUT    = 8;
	localparam int NLAYER   = 2;
	localparam int DW       = 16;
	localparam int AW       = 32;
	localparam int CH_BITS  = 2;
	localparam int PIX_BITS = 8;

	// Index of the final input channel of a pixel
	localparam logic [CH_BITS-1:0] LAST_CH = CH_BITS'(CHIN - 1);

	// Requantization takes DW-1 bits starting here
	localparam int QSHIFT = 14;

	// Table kinds
	localparam int KIND_WEIGHT = 0;
	localparam int KIND_BIAS   = 1;

	// Configuration register map
	localparam logic REG_CTRL  = 1'b0;
	localparam logic REG_COUNT = 1'b1;

	////////////////////////////////////////////////////////////
	// Data types
	////////////////////////////////////////////////////////////
	typedef logic signed [DW-1:0] data_t;
	typedef logic signed [AW-1:0] acc_t;

	// One weight per output lane
	typedef data_t [CHOUT-1:0] weight_vec_t;
	typedef acc_t  [CHOUT-1:0] bias_vec_t;
	typedef data_t [CHOUT-1:0] ofm_vec_t;

	////////////////////////////////////////////////////////////
	// Table contents
	////////////////////////////////////////////////////////////
	// Weight rule, values span -9..9 in steps of 512
	function automatic data_t weight_value(input int layer, input int ci, input int co);
		return data_t'((((ci * 5 + co * 3 + layer * 7) % 19) - 9) * 512);
	endfunction

	// Bias rule, values span -6..6 in steps of 4096
	function automatic acc_t bias_value(input int layer, input int co);
		return acc_t'((((co * 11 + layer * 5) % 13) - 6) * 4096);
	endfunction

endpackage

/* rtl/coef_table.sv */
// Constant coefficient table, one packed row vector per layer and row index
`timescale 1ns/1ps

module coef_table #(
	parameter type payload_t = expand_pkg::weight_vec_t,
	parameter int  ROWS      = expand_pkg::CHIN,
	parameter int  KIND      = expand_pkg::KIND_WEIGHT,
	localparam int RW        = (ROWS > 1) ? $clog2(ROWS) : 1
) (
	input  logic          layer_sel,
	input  logic [RW-1:0] row,
	output payload_t      value
);

	// Element width inside one row
	localparam int EW = (KIND == expand_pkg::KIND_WEIGHT) ? expand_pkg::DW : expand_pkg::AW;

	// Build one row as a flat vector, lane 0 in the low bits
	function automatic payload_t row_value(input int layer, input int r);
		logic [$bits(payload_t)-1:0] flat;
		expand_pkg::acc_t v;
		flat = '0;
		for (int co = 0; co < expand_pkg::CHOUT; co++) begin
			// Weights are sign extended first, then cut back to EW
			if (KIND == expand_pkg::KIND_WEIGHT) begin
				v = expand_pkg::weight_value(layer, r, co);
			end else begin
				v = expand_pkg::bias_value(layer, co);
			end
			flat[co*EW +: EW] = v[EW-1:0];
		end
		return payload_t'(flat);
	endfunction

	payload_t table_q [expand_pkg::NLAYER][ROWS];

	// Constant rows for every layer
	for (genvar l = 0; l < expand_pkg::NLAYER; l++) begin : g_layer
		for (genvar r = 0; r < ROWS; r++) begin : g_row
			assign table_q[l][r] = row_value(l, r);
		end
	end

	// Plain combinational read
	assign value = table_q[layer_sel][row];

endmodule

/* rtl/mac_lane.sv */
// Signed 16x16 multiply-accumulate lane with clear and enable
`timescale 1ns/1ps

module mac_lane (
	input  logic              clk,
	input  logic              rst_gen,
	input  logic              en,
	input  logic              clr,
	input  expand_pkg::data_t pix,
	input  expand_pkg::data_t ker,
	output expand_pkg::acc_t  acc
);

	expand_pkg::acc_t prod;

	// Full precision product, both operands signed
	assign prod = pix * ker;

	always_ff @(posedge clk) begin
		if (rst_gen) begin
			acc <= '0;
		end else if (en) begin
			// First channel of a pixel starts a fresh sum
			if (clr) begin
				acc <= prod;
			end else begin
				acc <= acc + prod;
			end
		end
	end

endmodule

/* rtl/expand_cfg.sv */
// Configuration and status registers for the expand engine: layer, count, start, busy, done
`timescale 1ns/1ps

module expand_cfg (
	input  logic                            clk,
	input  logic                            rst_gen,
	input  logic                            cfg_wr,
	input  logic                            cfg_addr,
	input  logic [7:0]                      cfg_wdata,
	input  logic                            pix_retired,
	output logic                            layer_sel,
	output logic [expand_pkg::PIX_BITS-1:0] pix_count,
	output logic                            run,
	output logic                            busy,
	output logic                            done,
	output logic [expand_pkg::PIX_BITS-1:0] pix_done
);

	logic wr_ok;
	logic start;

	// Writes only land while idle
	assign wr_ok = cfg_wr && !busy;

	// Bit 1 of a control write starts a run
	assign start = wr_ok && (cfg_addr == expand_pkg::REG_CTRL) && cfg_wdata[1];

	// Sequencer accepts input for the whole run
	assign run = busy;

	////////////////////////////////////////////////////////////
	// Configuration registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst_gen) begin
			layer_sel <= 1'b0;
			pix_count <= '0;
		end else if (wr_ok) begin
			if (cfg_addr == expand_pkg::REG_CTRL) begin
				layer_sel <= cfg_wdata[0];
			end else begin
				pix_count <= cfg_wdata;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Run status
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst_gen) begin
			busy     <= 1'b0;
			done     <= 1'b0;
			pix_done <= '0;
		end else if (start) begin
			busy     <= 1'b1;
			done     <= 1'b0;
			pix_done <= '0;
		end else if (busy) begin
			// Every pixel retired, close the run
			if (pix_done == pix_count) begin
				busy <= 1'b0;
				done <= 1'b1;
			end else if (pix_retired) begin
				pix_done <= pix_done + 1'b1;
			end
		end
	end

endmodule

/* rtl/expand_sequencer.sv */
// Input sequencer for the expand engine: four-phase intake, channel walk and MAC control
`timescale 1ns/1ps

module expand_sequencer (
	input  logic                            clk,
	input  logic                            rst_gen,
	input  logic                            run,
	input  logic [expand_pkg::PIX_BITS-1:0] pix_count,
	input  logic                            in_req,
	input  expand_pkg::data_t               in_data,
	output logic                            in_ack,
	output logic [expand_pkg::CH_BITS-1:0]  ch_idx,
	output expand_pkg::data_t               pix_in,
	output logic                            acc_en,
	output logic                            acc_clr,
	input  logic                            ofm_full,
	output logic                            ofm_load
);

	// Pixels accepted so far in this run
	logic [expand_pkg::PIX_BITS-1:0] pix_acc;
	// Completed pixel still sitting in the lanes
	logic pending;
	logic last_ch;
	logic accept;

	assign last_ch = (ch_idx == expand_pkg::LAST_CH);

	// New request, room in the run, lanes free
	assign accept = in_req && !in_ack && run && (pix_acc != pix_count) && !pending;

	////////////////////////////////////////////////////////////
	// Input handshake
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst_gen) begin
			in_ack <= 1'b0;
		end else if (accept) begin
			in_ack <= 1'b1;
		end else if (in_ack && !in_req) begin
			// Source has let go, close the cycle
			in_ack <= 1'b0;
		end
	end

	// Channel value captured with the acknowledge
	always_ff @(posedge clk) begin
		if (accept) begin
			pix_in <= in_data;
		end
	end

	////////////////////////////////////////////////////////////
	// Channel walk and accumulate control
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst_gen) begin
			acc_en <= 1'b0;
		end else begin
			acc_en <= accept;
		end
	end

	// Channel 0 replaces the accumulator
	assign acc_clr = acc_en && (ch_idx == '0);

	// Row index steps after each accumulate
	always_ff @(posedge clk) begin
		if (rst_gen || !run) begin
			ch_idx <= '0;
		end else if (acc_en) begin
			if (last_ch) begin
				ch_idx <= '0;
			end else begin
				ch_idx <= ch_idx + 1'b1;
			end
		end
	end

	// Count pixels as their last channel comes in
	always_ff @(posedge clk) begin
		if (rst_gen || !run) begin
			pix_acc <= '0;
		end else if (accept && last_ch) begin
			pix_acc <= pix_acc + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Hand-off to the output stage
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst_gen) begin
			pending <= 1'b0;
		end else if (acc_en && last_ch) begin
			pending <= 1'b1;
		end else if (ofm_load) begin
			pending <= 1'b0;
		end
	end

	// Wait here while the output register is occupied
	assign ofm_load = pending && !ofm_full;

endmodule

/* rtl/ofm_stage.sv */
// Output stage: bias add, ReLU, requantization and four-phase output handshake
`timescale 1ns/1ps

module ofm_stage (
	input  logic                                         clk,
	input  logic                                         rst_gen,
	input  logic                                         load,
	input  expand_pkg::acc_t [expand_pkg::CHOUT-1:0]     acc_in,
	input  expand_pkg::bias_vec_t                        bias,
	output logic                                         full,
	output logic                                         out_req,
	output expand_pkg::ofm_vec_t                         out_data,
	input  logic                                         out_ack,
	output logic                                         retired
);

	expand_pkg::acc_t sum [expand_pkg::CHOUT];

	// Bias add per lane, wraps in 32 bits
	always_comb begin
		for (int i = 0; i < expand_pkg::CHOUT; i++) begin
			sum[i] = acc_in[i] + bias[i];
		end
	end

	////////////////////////////////////////////////////////////
	// ReLU and requantization into the output register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (load) begin
			for (int i = 0; i < expand_pkg::CHOUT; i++) begin
				// Negative sums clamp to zero
				if (sum[i][expand_pkg::AW-1]) begin
					out_data[i] <= '0;
				end else begin
					out_data[i] <= {1'b0,
						sum[i][expand_pkg::QSHIFT+expand_pkg::DW-2:expand_pkg::QSHIFT]};
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Output handshake
	////////////////////////////////////////////////////////////
	// Consumer took the vector
	assign retired = out_req && out_ack;

	always_ff @(posedge clk) begin
		if (rst_gen) begin
			out_req <= 1'b0;
			full    <= 1'b0;
		end else if (load) begin
			out_req <= 1'b1;
			full    <= 1'b1;
		end else begin
			if (retired) begin
				out_req <= 1'b0;
			end
			// Register frees once the ack has gone low again
			if (!out_req && !out_ack) begin
				full <= 1'b0;
			end
		end
	end

endmodule

/* rtl/expand1x1_top.sv */
// Top level of the 1x1 expand engine: config, sequencer, tables, MAC lanes, output stage
`timescale 1ns/1ps

module expand1x1_top (
	input  logic                            clk,
	input  logic                            rst_gen,
	// Configuration port
	input  logic                            cfg_wr,
	input  logic                            cfg_addr,
	input  logic [7:0]                      cfg_wdata,
	// Status
	output logic                            busy,
	output logic                            done,
	output logic [expand_pkg::PIX_BITS-1:0] pix_done,
	// Input stream
	input  logic                            in_req,
	input  expand_pkg::data_t               in_data,
	output logic                            in_ack,
	// Output stream
	output logic                            out_req,
	output expand_pkg::ofm_vec_t            out_data,
	input  logic                            out_ack
);

	logic                                     layer_sel;
	logic [expand_pkg::PIX_BITS-1:0]          pix_count;
	logic                                     run;
	logic                                     pix_retired;
	logic [expand_pkg::CH_BITS-1:0]           ch_idx;
	expand_pkg::data_t                        pix_in;
	logic                                     acc_en;
	logic                                     acc_clr;
	logic                                     ofm_full;
	logic                                     ofm_load;
	expand_pkg::weight_vec_t                  w_row;
	expand_pkg::bias_vec_t                    b_vec;
	expand_pkg::acc_t [expand_pkg::CHOUT-1:0] acc_vec;

	////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////
	expand_cfg u_cfg (
		.clk, .rst_gen, .cfg_wr, .cfg_addr, .cfg_wdata,
		.pix_retired, .layer_sel, .pix_count, .run,
		.busy, .done, .pix_done
	);

	expand_sequencer u_seq (
		.clk, .rst_gen, .run, .pix_count, .in_req, .in_data, .in_ack,
		.ch_idx, .pix_in, .acc_en, .acc_clr, .ofm_full, .ofm_load
	);

	////////////////////////////////////////////////////////////
	// Coefficient tables
	////////////////////////////////////////////////////////////
	// Weight row follows the current channel
	coef_table #(
		.payload_t(expand_pkg::weight_vec_t),
		.ROWS(expand_pkg::CHIN),
		.KIND(expand_pkg::KIND_WEIGHT)
	) u_weights (.layer_sel, .row(ch_idx), .value(w_row));

	// Single bias row per layer
	coef_table #(
		.payload_t(expand_pkg::bias_vec_t),
		.ROWS(1),
		.KIND(expand_pkg::KIND_BIAS)
	) u_biases (.layer_sel, .row(1'b0), .value(b_vec));

	////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////
	for (genvar i = 0; i < expand_pkg::CHOUT; i++) begin : g_lane
		mac_lane u_lane (
			.clk, .rst_gen, .en(acc_en), .clr(acc_clr),
			.pix(pix_in), .ker(w_row[i]), .acc(acc_vec[i])
		);
	end

	ofm_stage u_ofm (
		.clk, .rst_gen, .load(ofm_load), .acc_in(acc_vec), .bias(b_vec),
		.full(ofm_full), .out_req, .out_data, .out_ack, .retired(pix_retired)
	);

endmodule

/* tb/expand1x1_properties.sv */
// Handshake and status assertions for the 1x1 expand engine, bound to the top level
`timescale 1ns/1ps

module expand1x1_properties (
	input logic                 clk,
	input logic                 rst_gen,
	input logic                 in_req,
	input logic                 in_ack,
	input logic                 out_req,
	input logic                 out_ack,
	input expand_pkg::ofm_vec_t out_data,
	input logic                 busy,
	input logic                 done
);

	////////////////////////////////////////////////////////////
	// Input stream
	////////////////////////////////////////////////////////////
	// Ack only answers a pending request
	assert property (@(posedge clk) disable iff (rst_gen) $rose(in_ack) |-> $past(in_req))
		else $error("in_ack rose without in_req being high");

	////////////////////////////////////////////////////////////
	// Output stream
	////////////////////////////////////////////////////////////
	// Vector held for the whole request phase
	assert property (@(posedge clk) disable iff (rst_gen)
		out_req && $past(out_req) |-> $stable(out_data))
		else $error("out_data changed while out_req was high");

	// New request only after the previous ack has gone low
	assert property (@(posedge clk) disable iff (rst_gen) $rose(out_req) |-> !$past(out_ack))
		else $error("out_req rose again before out_ack was low");

	// Status flags exclusive
	assert property (@(posedge clk) disable iff (rst_gen) !(busy && done))
		else $error("busy and done were high at the same time");

endmodule

bind expand1x1_top expand1x1_properties u_props (
	.clk(clk), .rst_gen(rst_gen), .in_req(in_req), .in_ack(in_ack),
	.out_req(out_req), .out_ack(out_ack), .out_data(out_data),
	.busy(busy), .done(done)
);

/* tb/expand1x1_tb.sv */
// Table-driven testbench for the 1x1 expand engine with a reference model and watchdog
`timescale 1ns/1ps

module expand1x1_tb;

	localparam int NTEST = 5;
	// Cycle budget per pixel, covers handshakes and the longest ack delay
	localparam int PIX_CYCLES = 80;
	localparam int MARGIN_CYCLES = 1000;

	logic                            clk;
	logic                            rst_gen;
	logic                            cfg_wr;
	logic                            cfg_addr;
	logic [7:0]                      cfg_wdata;
	logic                            busy;
	logic                            done;
	logic [expand_pkg::PIX_BITS-1:0] pix_done;
	logic                            in_req;
	expand_pkg::data_t               in_data;
	logic                            in_ack;
	logic                            out_req;
	expand_pkg::ofm_vec_t            out_data;
	logic                            out_ack;

	// Stimulus table: layer, pixel count, random ack delays, pixel seed offset
	int t_layer [NTEST] = '{0, 1, 0, 1, 0};
	int t_count [NTEST] = '{8, 8, 20, 13, 3};
	int t_ackrnd[NTEST] = '{0, 0, 1, 1, 0};
	int t_seed  [NTEST] = '{0, 0, 11, 23, 37};

	integer               seed;
	integer               ack_seed;
	logic                 ack_random;
	int                   n_checks;
	int                   n_errors;
	int                   n_zero;
	int                   n_pos;
	expand_pkg::ofm_vec_t exp_q[$];
	expand_pkg::ofm_vec_t got_q[$];

	expand1x1_top UUT (
		.clk(clk), .rst_gen(rst_gen),
		.cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
		.busy(busy), .done(done), .pix_done(pix_done),
		.in_req(in_req), .in_data(in_data), .in_ack(in_ack),
		.out_req(out_req), .out_data(out_data), .out_ack(out_ack)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////
	function automatic int ref_weight(input int layer, input int ci, input int co);
		return (((ci * 5 + co * 3 + layer * 7) % 19) - 9) * 512;
	endfunction

	function automatic int ref_bias(input int layer, input int co);
		return (((co * 11 + layer * 5) % 13) - 6) * 4096;
	endfunction

	// ReLU then bits 28..14 under a zero sign bit
	function automatic logic [15:0] requant(input int s);
		logic [31:0] u;
		u = s;
		if (s < 0) begin
			return 16'h0000;
		end
		return {1'b0, u[28:14]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		n_checks++;
		if (exp_v !== act_v) begin
			n_errors++;
			$display("MISMATCH t=%0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Drivers, all aligned 1 ns after a rising edge
	////////////////////////////////////////////////////////////
	task automatic write_cfg(input logic addr, input logic [7:0] data);
		cfg_addr  = addr;
		cfg_wdata = data;
		cfg_wr    = 1'b1;
		@(posedge clk);
		#1;
		cfg_wr = 1'b0;
	endtask

	// One channel value through the four-phase handshake
	task automatic send_value(input expand_pkg::data_t v);
		in_data = v;
		in_req  = 1'b1;
		do begin
			@(posedge clk);
			#1;
		end while (!in_ack);
		in_req = 1'b0;
		do begin
			@(posedge clk);
			#1;
		end while (in_ack);
	endtask

	// Random pixel, expected vector queued before sending
	task automatic feed_pixel(input int layer);
		expand_pkg::data_t    px[expand_pkg::CHIN];
		expand_pkg::ofm_vec_t ev;
		int                   acc;
		for (int ci = 0; ci < expand_pkg::CHIN; ci++) begin
			px[ci] = expand_pkg::data_t'($random(seed));
		end
		for (int co = 0; co < expand_pkg::CHOUT; co++) begin
			acc = ref_bias(layer, co);
			for (int ci = 0; ci < expand_pkg::CHIN; ci++) begin
				acc += int'(px[ci]) * ref_weight(layer, ci, co);
			end
			ev[co] = requant(acc);
			if (acc < 0) n_zero++;
			else n_pos++;
		end
		exp_q.push_back(ev);
		for (int ci = 0; ci < expand_pkg::CHIN; ci++) begin
			send_value(px[ci]);
		end
	endtask

	// Consumer, optional random delay before each ack
	initial begin : consumer
		int delay;
		forever begin
			@(posedge clk);
			#1;
			if (out_req && !out_ack) begin
				got_q.push_back(out_data);
				delay = ack_random ? ($random(ack_seed) & 7) : 0;
				repeat (delay) begin
					@(posedge clk);
					#1;
				end
				out_ack = 1'b1;
				do begin
					@(posedge clk);
					#1;
				end while (out_req);
				out_ack = 1'b0;
			end
		end
	end

	initial begin : watchdog
		int total;
		total = 0;
		for (int t = 0; t < NTEST; t++) begin
			total += t_count[t];
		end
		repeat (total * PIX_CYCLES + MARGIN_CYCLES) @(posedge clk);
		$display("Timeout: the runs did not complete within the budget for %0d pixels", total);
		$display("TEST FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////
	initial begin
		int   errs_before;
		logic extra_ack;
		rst_gen    = 1'b1;
		cfg_wr     = 1'b0;
		cfg_addr   = 1'b0;
		cfg_wdata  = 8'h00;
		in_req     = 1'b0;
		in_data    = '0;
		out_ack    = 1'b0;
		ack_seed   = 4726;
		ack_random = 1'b0;
		n_checks   = 0;
		n_errors   = 0;
		n_zero     = 0;
		n_pos      = 0;
		repeat (8) @(posedge clk);
		#1;
		rst_gen = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		for (int t = 0; t < NTEST; t++) begin
			errs_before = n_errors;
			seed        = 4726 + t_seed[t];
			ack_random  = t_ackrnd[t][0];
			exp_q.delete();
			got_q.delete();
			write_cfg(expand_pkg::REG_COUNT, 8'(t_count[t]));
			write_cfg(expand_pkg::REG_CTRL, {6'b0, 1'b1, 1'(t_layer[t])});
			check_value("busy", 1, busy);
			check_value("done", 0, done);
			check_value("pix_done", 0, pix_done);
			for (int p = 0; p < t_count[t]; p++) begin
				feed_pixel(t_layer[t]);
			end
			// One extra value offered past the end of the run
			in_data   = 16'sh1234;
			in_req    = 1'b1;
			extra_ack = 1'b0;
			while (!done) begin
				@(posedge clk);
				#1;
				if (in_ack) extra_ack = 1'b1;
			end
			in_req = 1'b0;
			check_value("in_ack", 0, extra_ack);
			check_value("busy", 0, busy);
			check_value("pix_done", t_count[t], pix_done);
			check_value("out_data count", t_count[t], got_q.size());
			for (int p = 0; p < got_q.size() && p < exp_q.size(); p++) begin
				for (int co = 0; co < expand_pkg::CHOUT; co++) begin
					check_value($sformatf("out_data[%0d] pixel %0d", co, p),
						exp_q[p][co], got_q[p][co]);
				end
			end
			$display("test %0d: layer %0d, %0d pixels, %s acks, %0d errors", t, t_layer[t],
				t_count[t], t_ackrnd[t] ? "random" : "immediate", n_errors - errs_before);
			@(posedge clk);
			#1;
		end
		// Both sides of the ReLU reached
		check_value("zero lanes seen", 1, n_zero > 0);
		check_value("positive lanes seen", 1, n_pos > 0);
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* expand1x1_top.f */
rtl/expand_pkg.sv
rtl/coef_table.sv
rtl/mac_lane.sv
rtl/expand_cfg.sv
rtl/expand_sequencer.sv
rtl/ofm_stage.sv
rtl/expand1x1_top.sv
tb/expand1x1_properties.sv
tb/expand1x1_tb.sv

/* Makefile */
# Verilator build and run for the 1x1 expand engine

BIN  := obj_dir/Vexpand1x1_tb
SRCS := $(wildcard rtl/*.sv tb/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) expand1x1_top.f
	verilator --binary --timing --assert -Wno-fatal -f expand1x1_top.f \
		--top-module expand1x1_tb -Mdir obj_dir

# Status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
